/* test/rx_input.dat */
# group channel size dest addr data, addr and data in hex
# size 0 byte 1 half 2 word; dest 0 l2 1 periph 2 cluster 3 custom
0 0 0 0 0100 000000a5
0 1 1 0 0102 0000beef
0 2 2 0 0200 12345678
0 3 0 0 0203 0000003c
1 1 1 0 0307 0000c0de
1 2 2 0 0401 a1b2c3d4
1 3 2 0 0502 55667788
1 0 2 0 0603 99aabbcc
2 2 2 1 0010 cafef00d
2 3 1 2 0022 00001234
2 0 0 3 0031 0000005a
2 1 2 3 0045 deadbeef
3 2 2 0 fffe 01020304
4 3 1 1 00a3 0000abcd
4 1 0 2 00b1 000000ff
4 0 2 3 0c0c 0badf00d
5 0 1 3 0d0e 00007e57
5 3 2 1 0e0f f00dcafe
5 2 1 0 0f01 00004321
6 1 1 2 1233 00005aa5

/* all.f */
source/udma_rx_pkg.sv
source/udma_rx_arbiter.sv
source/udma_rx_sample.sv
source/udma_rx_fifo.sv
source/udma_rx_l2_write.sv
source/udma_rx_channels.sv
test/udma_rx_assert.sv
test/tb_udma_rx.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the udma rx testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_udma_rx -f all.f -o tb_udma_rx

./obj_dir/tb_udma_rx | tee sim.log

if grep -q "RESULT: PASS" sim.log
then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* test/tb_udma_rx.sv */
////////////////////////////////////////
// testbench for the udma rx channels with
// file-driven items and l2 beat checks
////////////////////////////////////////

`default_nettype none

module tb_udma_rx;

    import udma_rx_pkg::*;

    localparam int         N_CH       = 4;
    localparam int         TIMEOUT    = 4000;
    localparam logic [7:0] CUSTOM_PFX = 8'h2B;
    localparam logic [7:0] ALT_PFX    = 8'h3E;   // custom prefix of the second pass

    typedef struct packed {
        bus_addr_t addr;
        be_t       be;
        data_t     wdata;
    } beat_t;

    logic                clk;
    logic                rstn;
    rx_item_t [N_CH-1:0] ch_item;
    logic     [N_CH-1:0] ch_valid;
    logic     [N_CH-1:0] ch_ready;
    logic     [7:0]      l2_dest;
    logic                l2_req;
    logic                l2_gnt;
    bus_addr_t           l2_addr;
    be_t                 l2_be;
    data_t               l2_wdata;

    rx_item_t file_item[$];
    int       file_ch[$];
    int       file_grp[$];
    int       order_q[$];   // predicted acceptance order
    beat_t    exp_q[$];     // expected l2 beats in write order
    int       last_ch;

    udma_rx_channels #(
        .N_CHANNELS (N_CH),
        .FIFO_DEPTH (4)
    ) udma_rx_channels_i (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .ch_item_i  (ch_item),
        .ch_valid_i (ch_valid),
        .ch_ready_o (ch_ready),
        .l2_dest_i  (l2_dest),
        .l2_req_o   (l2_req),
        .l2_gnt_i   (l2_gnt),
        .l2_addr_o  (l2_addr),
        .l2_be_o    (l2_be),
        .l2_wdata_o (l2_wdata)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_addr(input bus_addr_t exp, input bus_addr_t act);
        if (act !== exp)
        begin
            fail_run($sformatf("mismatch at %0t: l2_addr_o expected %h actual %h",
                               $time, exp, act));
        end
    endtask

    task automatic check_be(input be_t exp, input be_t act);
        if (act !== exp)
        begin
            fail_run($sformatf("mismatch at %0t: l2_be_o expected %h actual %h",
                               $time, exp, act));
        end
    endtask

    task automatic check_wdata(input data_t exp, input data_t act);
        if (act !== exp)
        begin
            fail_run($sformatf("mismatch at %0t: l2_wdata_o expected %h actual %h",
                               $time, exp, act));
        end
    endtask

    task automatic check_ready(input logic [N_CH-1:0] exp, input logic [N_CH-1:0] act);
        if (act !== exp)
        begin
            fail_run($sformatf("mismatch at %0t: ch_ready_o expected %b actual %b",
                               $time, exp, act));
        end
    endtask

    function automatic bus_addr_t region_addr(input dest_e dest, input logic [15:0] word);
        bus_addr_t a;
        a = {16'h0, word};
        case (dest)
            DEST_L2:      a[31:24] = PREFIX_L2;
            DEST_PERIPH:  a[31:20] = PREFIX_PERIPH;
            DEST_CLUSTER: a[31:24] = PREFIX_CLUSTER;
            default:      a[31:24] = l2_dest;
        endcase
        return a;
    endfunction

    // byte k of the data lands at byte position offset+k of two words
    function automatic void expand_item(input rx_item_t it);
        beat_t beats[2];
        int    nb;
        int    pos;
        nb = (it.size == SIZE_BYTE) ? 1 : (it.size == SIZE_HALF) ? 2 : 4;
        for (int b = 0; b < 2; b++)
        begin
            beats[b]      = '0;
            beats[b].addr = region_addr(it.dest, {it.addr[15:2], 2'b00} + 16'(4 * b));
        end
        for (int k = 0; k < 4; k++)
        begin
            pos = int'(it.addr[1:0]) + k;
            beats[pos / 4].wdata[(pos % 4) * 8 +: 8] = it.data[k * 8 +: 8];
            if (k < nb)
            begin
                beats[pos / 4].be[pos % 4] = 1'b1;
            end
        end
        exp_q.push_back(beats[0]);
        if (beats[1].be != '0)
        begin
            exp_q.push_back(beats[1]);   // non-aligned second beat
        end
    endfunction

    task automatic load_items();
        int          fd;
        string       line;
        int          grp;
        int          ch;
        int          sz;
        int          dst;
        int unsigned addr_v;
        int unsigned data_v;
        rx_item_t    it;
        fd = $fopen("test/rx_input.dat", "r");
        if (fd == 0)
        begin
            fail_run("could not open test/rx_input.dat");
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                if ($sscanf(line, "%d %d %d %d %h %h", grp, ch, sz, dst, addr_v, data_v) == 6)
                begin
                    it.data = data_t'(data_v);
                    it.size = size_e'(sz[1:0]);
                    it.dest = dest_e'(dst[1:0]);
                    it.addr = addr_t'(addr_v);
                    file_item.push_back(it);
                    file_ch.push_back(ch);
                    file_grp.push_back(grp);
                end
            end
        end
        $fclose(fd);
    endtask

    // offer one group at once and hold each item until its ready pulse
    task automatic run_group(input int first, input int last);
        logic [N_CH-1:0] mask;
        logic [N_CH-1:0] seen;
        int              cnt;
        int              c;
        mask = '0;
        for (int i = first; i <= last; i++)
        begin
            ch_item[file_ch[i]] = file_item[i];
            mask[file_ch[i]]    = 1'b1;
        end
        for (int k = 1; k <= N_CH; k++)
        begin
            c = (last_ch + k) % N_CH;   // lowest requester above the last grant
            if (mask[c])
            begin
                order_q.push_back(c);
            end
        end
        last_ch  = order_q[$];
        ch_valid = mask;
        cnt      = 0;
        while (ch_valid != '0 && cnt < TIMEOUT)
        begin
            @(negedge clk);
            seen = ch_ready;
            @(posedge clk);
            #1;
            ch_valid = ch_valid & ~seen;
            cnt++;
        end
        if (ch_valid != '0)
        begin
            fail_run("timeout: a channel item was never accepted");
        end
    endtask

    ////////////////////////////////////////
    // mid-cycle monitor
    ////////////////////////////////////////

    always @(negedge clk)
    begin : monitor
        beat_t exp;
        int    c;
        if (rstn && ch_ready != '0)
        begin
            if (order_q.size() == 0)
            begin
                fail_run("ch_ready_o pulsed while no channel item was waiting");
            end
            else
            begin
                c = order_q.pop_front();
                check_ready(N_CH'(1) << c, ch_ready);
                expand_item(ch_item[c]);
            end
        end
        if (rstn && l2_req && l2_gnt)
        begin
            if (exp_q.size() == 0)
            begin
                fail_run("an l2 write was granted but no write was expected");
            end
            else
            begin
                exp = exp_q.pop_front();
                check_addr(exp.addr, l2_addr);
                check_be(exp.be, l2_be);
                check_wdata(exp.wdata, l2_wdata);
            end
        end
    end

    // grant with long mostly-low stretches
    initial
    begin : grant_gen
        int unsigned pct;
        int unsigned cyc;
        void'($urandom(32'h0d1ef579));
        l2_gnt = 1'b0;
        cyc    = 0;
        forever
        begin
            @(posedge clk);
            #1;
            pct    = cyc[6] ? 6 : 70;
            l2_gnt = (($urandom % 100) < pct);
            cyc++;
        end
    end

    initial
    begin : main
        int idx;
        int first;
        int cnt;
        clk      = 1'b0;
        rstn     = 1'b0;
        ch_valid = '0;
        ch_item  = '0;
        l2_dest  = CUSTOM_PFX;
        last_ch  = N_CH - 1;
        load_items();
        if (file_item.size() == 0)
        begin
            fail_run("no items were read from test/rx_input.dat");
        end
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        // the second pass repeats all items with another custom prefix
        for (int pass = 0; pass < 2; pass++)
        begin
            idx = 0;
            while (idx < file_item.size())
            begin
                first = idx;
                while (idx < file_item.size() && file_grp[idx] == file_grp[first])
                begin
                    idx++;
                end
                run_group(first, idx - 1);
            end
            cnt = 0;
            while ((exp_q.size() != 0 || order_q.size() != 0) && cnt < TIMEOUT)
            begin
                @(posedge clk);
                cnt++;
            end
            if (pass == 0)
            begin
                if (exp_q.size() != 0 || order_q.size() != 0)
                begin
                    fail_run("timeout: the first pass of l2 writes did not finish");
                end
                #1;
                l2_dest = ALT_PFX;   // no write is pending here
            end
        end
        repeat (8) @(posedge clk);   // quiet time to catch stray writes
        if (exp_q.size() != 0 || order_q.size() != 0)
        begin
            fail_run("timeout: not all expected l2 writes were seen");
        end
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/udma_rx_assert.sv */
////////////////////////////////////////
// l2 request protocol assertions
////////////////////////////////////////

`default_nettype none

module udma_rx_assert (
    input logic                   clk_i,
    input logic                   rstn_i,
    input logic                   l2_req_i,
    input logic                   l2_gnt_i,
    input udma_rx_pkg::bus_addr_t l2_addr_i,
    input udma_rx_pkg::be_t       l2_be_i,
    input udma_rx_pkg::data_t     l2_wdata_i
);

    // a waiting beat holds its address, enables and data
    hold_beat: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (l2_req_i && !l2_gnt_i) |=> (l2_req_i && $stable(l2_addr_i) &&
                                     $stable(l2_be_i) && $stable(l2_wdata_i)))
        else $error("l2 beat changed while waiting for a grant");

    be_nonzero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_i |-> (l2_be_i != '0))
        else $error("l2 request with no byte enabled");

    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !l2_req_i)
        else $error("l2 request high right after reset");

endmodule

bind udma_rx_l2_write udma_rx_assert l2_assert_i (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .l2_req_i   (l2_req_o),
    .l2_gnt_i   (l2_gnt_i),
    .l2_addr_i  (l2_addr_o),
    .l2_be_i    (l2_be_o),
    .l2_wdata_i (l2_wdata_o)
);

`default_nettype wire

/* source/udma_rx_channels.sv */
////////////////////////////////////////
// udma rx channels top level
////////////////////////////////////////

`default_nettype none

module udma_rx_channels #(
    parameter int N_CHANNELS = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  udma_rx_pkg::rx_item_t [N_CHANNELS-1:0] ch_item_i,
    input  logic                  [N_CHANNELS-1:0] ch_valid_i,
    output logic                  [N_CHANNELS-1:0] ch_ready_o,
    input  logic                  [7:0]            l2_dest_i,
    output logic                                   l2_req_o,
    input  logic                                   l2_gnt_i,
    output udma_rx_pkg::bus_addr_t                 l2_addr_o,
    output udma_rx_pkg::be_t                       l2_be_o,
    output udma_rx_pkg::data_t                     l2_wdata_o
);

    import udma_rx_pkg::*;

    logic [N_CHANNELS-1:0] grant;
    logic                  any_grant;
    logic                  sample_en;   // also the grant acknowledge
    logic                  push;
    rx_item_t              sample_item;
    logic                  fifo_space;
    logic                  fifo_valid;
    rx_item_t              fifo_item;
    logic                  pop;

    udma_rx_arbiter #(
        .N_CHANNELS (N_CHANNELS)
    ) arbiter_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (ch_valid_i),
        .ack_i       (sample_en),
        .grant_o     (grant),
        .any_grant_o (any_grant)
    );

    udma_rx_sample #(
        .N_CHANNELS (N_CHANNELS)
    ) sample_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .ch_item_i    (ch_item_i),
        .grant_i      (grant),
        .any_grant_i  (any_grant),
        .fifo_space_i (fifo_space),
        .sample_en_o  (sample_en),
        .ch_ready_o   (ch_ready_o),
        .push_o       (push),
        .item_o       (sample_item)
    );

    udma_rx_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (push),
        .item_i  (sample_item),
        .space_o (fifo_space),
        .valid_o (fifo_valid),
        .pop_i   (pop),
        .item_o  (fifo_item)
    );

    udma_rx_l2_write l2_write_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .valid_i    (fifo_valid),
        .item_i     (fifo_item),
        .pop_o      (pop),
        .l2_dest_i  (l2_dest_i),
        .l2_req_o   (l2_req_o),
        .l2_gnt_i   (l2_gnt_i),
        .l2_addr_o  (l2_addr_o),
        .l2_be_o    (l2_be_o),
        .l2_wdata_o (l2_wdata_o)
    );

endmodule

`default_nettype wire

/* source/udma_rx_l2_write.sv */
////////////////////////////////////////
// l2 write stage, lanes, byte enables,
// region prefix and non-aligned split
////////////////////////////////////////

`default_nettype none

module udma_rx_l2_write (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   valid_i,
    input  udma_rx_pkg::rx_item_t  item_i,
    output logic                   pop_o,
    input  logic [7:0]             l2_dest_i,
    output logic                   l2_req_o,
    input  logic                   l2_gnt_i,
    output udma_rx_pkg::bus_addr_t l2_addr_o,
    output udma_rx_pkg::be_t       l2_be_o,
    output udma_rx_pkg::data_t     l2_wdata_o
);

    import udma_rx_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_SECOND
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic [1:0]  offset;
    logic        non_aligned;
    logic        is_second;
    logic [7:0]  size_mask;
    logic [7:0]  lane_mask;
    logic [63:0] lane_data;
    logic [13:0] word_idx;

    assign offset    = item_i.addr[1:0];
    assign is_second = (state_q == ST_SECOND);

    always_comb
    begin
        case (item_i.size)
            SIZE_BYTE: size_mask = 8'b0000_0001;
            SIZE_HALF: size_mask = 8'b0000_0011;
            SIZE_WORD: size_mask = 8'b0000_1111;
            default:   size_mask = 8'b0000_0000;
        endcase
    end

    assign non_aligned = ((item_i.size == SIZE_HALF) && (offset == 2'd3)) ||
                         ((item_i.size == SIZE_WORD) && (offset != 2'd0));

    // spread over two words with the low half as the first beat
    assign lane_mask = size_mask << offset;
    assign lane_data = {32'h0, item_i.data} << {offset, 3'b000};

    assign l2_be_o    = is_second ? lane_mask[7:4] : lane_mask[3:0];
    assign l2_wdata_o = is_second ? lane_data[63:32] : lane_data[31:0];

    ////////////////////////////////////////
    // bus address
    ////////////////////////////////////////

    assign word_idx = item_i.addr[15:2] + {13'd0, is_second};  // next word on beat 2

    always_comb
    begin
        l2_addr_o = {16'h0, word_idx, 2'b00};
        case (item_i.dest)
            DEST_L2:      l2_addr_o[31:24] = PREFIX_L2;
            DEST_PERIPH:  l2_addr_o[31:20] = PREFIX_PERIPH;
            DEST_CLUSTER: l2_addr_o[31:24] = PREFIX_CLUSTER;
            DEST_CUSTOM:  l2_addr_o[31:24] = l2_dest_i;
            default:      l2_addr_o[31:24] = PREFIX_L2;
        endcase
    end

    ////////////////////////////////////////
    // split fsm
    ////////////////////////////////////////

    assign l2_req_o = valid_i;
    assign pop_o    = valid_i && l2_gnt_i && (is_second || !non_aligned);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (valid_i && l2_gnt_i && non_aligned)
                begin
                    state_d = ST_SECOND;
                end
            end
            ST_SECOND:
            begin
                if (l2_gnt_i)
                begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q <= ST_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* source/udma_rx_fifo.sv */
////////////////////////////////////////
// fall-through fifo of l2 items
////////////////////////////////////////

`default_nettype none

module udma_rx_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  push_i,
    input  udma_rx_pkg::rx_item_t item_i,
    output logic                  space_o,
    output logic                  valid_o,
    input  logic                  pop_i,
    output udma_rx_pkg::rx_item_t item_o
);

    import udma_rx_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rx_item_t [DEPTH-1:0] mem;
    logic     [PTR_W-1:0] wr_ptr;
    logic     [PTR_W-1:0] rd_ptr;
    logic     [CNT_W-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    assign space_o = (count != CNT_W'(DEPTH));
    assign valid_o = (count != '0);
    assign do_push = push_i && space_o;   // push on a full fifo is held upstream
    assign do_pop  = pop_i && valid_o;
    assign item_o  = mem[rd_ptr];

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= item_i;
        end
    end

endmodule

`default_nettype wire

/* source/udma_rx_sample.sv */
////////////////////////////////////////
// input mux, ready pulses and sample reg
////////////////////////////////////////

`default_nettype none

module udma_rx_sample #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                      clk_i,
    input  logic                                      rstn_i,
    input  udma_rx_pkg::rx_item_t [N_CHANNELS-1:0]    ch_item_i,
    input  logic                  [N_CHANNELS-1:0]    grant_i,
    input  logic                                      any_grant_i,
    input  logic                                      fifo_space_i,
    output logic                                      sample_en_o,
    output logic                  [N_CHANNELS-1:0]    ch_ready_o,
    output logic                                      push_o,
    output udma_rx_pkg::rx_item_t                     item_o
);

    import udma_rx_pkg::*;

    rx_item_t sel_item;
    rx_item_t item_q;
    logic     valid_q;

    // sampling is allowed whenever the fifo can take one more item
    assign sample_en_o = fifo_space_i;
    assign ch_ready_o  = grant_i & {N_CHANNELS{fifo_space_i}};

    always_comb
    begin
        sel_item = '0;
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            if (grant_i[i])
            begin
                sel_item = ch_item_i[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            valid_q <= 1'b0;
        end
        else if (fifo_space_i)
        begin
            valid_q <= any_grant_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (fifo_space_i)
        begin
            item_q <= sel_item;
        end
    end

    // a held item keeps pushing until the fifo takes it
    assign push_o = valid_q;
    assign item_o = item_q;

endmodule

`default_nettype wire

/* source/udma_rx_arbiter.sv */
////////////////////////////////////////
// round-robin arbiter over rx channels
////////////////////////////////////////

`default_nettype none

module udma_rx_arbiter #(
    parameter int N_CHANNELS = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [N_CHANNELS-1:0] req_i,
    input  logic                  ack_i,
    output logic [N_CHANNELS-1:0] grant_o,
    output logic                  any_grant_o
);

    localparam int PTR_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    logic [PTR_W-1:0] last_ptr;   // index of the last acknowledged grant
    logic [PTR_W-1:0] grant_idx;

    // search starts just above the last grant and wraps
    always_comb
    begin
        int unsigned idx;
        grant_o     = '0;
        any_grant_o = 1'b0;
        grant_idx   = last_ptr;
        for (int i = 1; i <= N_CHANNELS; i++)
        begin
            idx = (int'(last_ptr) + i) % N_CHANNELS;
            if (!any_grant_o && req_i[idx])
            begin
                grant_o[idx] = 1'b1;
                any_grant_o  = 1'b1;
                grant_idx    = PTR_W'(idx);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            last_ptr <= PTR_W'(N_CHANNELS - 1);  // first search hits channel 0
        end
        else if (ack_i && any_grant_o)
        begin
            last_ptr <= grant_idx;
        end
    end

endmodule

`default_nettype wire

/* source/udma_rx_pkg.sv */
////////////////////////////////////////
// types, enums and region prefixes
// shared by the udma rx pipeline
////////////////////////////////////////

`default_nettype none

package udma_rx_pkg;

    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 32;
    localparam int BE_W      = DATA_W / 8;
    localparam int BUS_ADDR_W = 32;

    typedef logic [ADDR_W-1:0]     addr_t;     // local l2 address
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [BE_W-1:0]       be_t;
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    typedef enum logic [1:0] {
        DEST_L2      = 2'b00,
        DEST_PERIPH  = 2'b01,
        DEST_CLUSTER = 2'b10,
        DEST_CUSTOM  = 2'b11  // prefix comes from l2_dest_i
    } dest_e;

    localparam logic [7:0]  PREFIX_L2      = 8'h1C;
    localparam logic [11:0] PREFIX_PERIPH  = 12'h1A1;
    localparam logic [7:0]  PREFIX_CLUSTER = 8'h10;

    // one received item as offered by a channel
    typedef struct packed {
        data_t data;
        size_e size;
        dest_e dest;
        addr_t addr;
    } rx_item_t;

endpackage

`default_nettype wire
